/* source/rv_pkg.sv */
package rv_pkg;

    localparam int xlen = 64;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_mulw,
        alu_divw
    } alu_op_e;

    // alu_w is the low word of the alu result, sign extended
    typedef enum logic [2:0] {
        wb_alu,
        wb_alu_w,
        wb_upper,
        wb_pc4,
        wb_load
    } wb_sel_e;

    typedef enum logic [1:0] {
        size_b,
        size_h,
        size_w,
        size_d
    } mem_size_e;

    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge
    } br_cond_e;

    typedef struct packed {
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [xlen-1:0] imm;
        alu_op_e         alu_op;
        logic            op_a_pc;
        logic            op_b_imm;
        logic            is_word;
        wb_sel_e         wb_sel;
        logic            reg_write;
        br_cond_e        br_cond;
        logic            jal;
        logic            jalr;
        logic            load;
        logic            store;
        logic            load_unsigned;
        mem_size_e       mem_size;
        logic            ebreak;
    } dec_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic [7:0]      wmask;
        logic            we;
        logic            re;
    } mem_req_t;

endpackage

/* source/rv_fetch.sv */
`timescale 1ns/100ps

module rv_fetch #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [rv_pkg::xlen-1:0] next_pc,
    input  logic                    halt_req,
    input  logic [rv_pkg::xlen-1:0] a0_value,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic                    halt,
    output logic [rv_pkg::xlen-1:0] exit_code
);

    // pc stays on the ebreak, so nothing after it ever executes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc        <= reset_pc;
            halt      <= 1'b0;
            exit_code <= '0;
        end else if (!halt) begin
            if (halt_req) begin
                halt      <= 1'b1;
                exit_code <= a0_value;
            end else begin
                pc <= next_pc;
            end
        end
    end

endmodule

/* source/rv_decode.sv */
`timescale 1ns/100ps

module rv_decode (
    input  logic [31:0]  instr,
    output rv_pkg::dec_t dec
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [rv_pkg::xlen-1:0] imm_i;
    logic [rv_pkg::xlen-1:0] imm_s;
    logic [rv_pkg::xlen-1:0] imm_b;
    logic [rv_pkg::xlen-1:0] imm_u;
    logic [rv_pkg::xlen-1:0] imm_j;
    logic                    legal;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        legal   = 1'b1;
        dec     = '0;
        dec.rd  = instr[11:7];
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        case (opcode)
            7'b0110111: begin
                dec.imm       = imm_u;
                dec.wb_sel    = rv_pkg::wb_upper;
                dec.reg_write = 1'b1;
            end
            7'b0010111: begin
                dec.imm       = imm_u;
                dec.op_a_pc   = 1'b1;
                dec.op_b_imm  = 1'b1;
                dec.reg_write = 1'b1;
            end
            7'b0010011: begin
                dec.imm       = imm_i;
                dec.op_b_imm  = 1'b1;
                dec.reg_write = 1'b1;
                // shamt sits in imm[5:0], srai also carries imm[10]
                case (funct3)
                    3'b000: dec.alu_op = rv_pkg::alu_add;
                    3'b001: begin
                        if (funct7[6:1] == 6'b000000) dec.alu_op = rv_pkg::alu_sll;
                        else legal = 1'b0;
                    end
                    3'b010: dec.alu_op = rv_pkg::alu_slt;
                    3'b100: dec.alu_op = rv_pkg::alu_xor;
                    3'b101: begin
                        if (funct7[6:1] == 6'b000000) dec.alu_op = rv_pkg::alu_srl;
                        else if (funct7[6:1] == 6'b010000) dec.alu_op = rv_pkg::alu_sra;
                        else legal = 1'b0;
                    end
                    3'b110: dec.alu_op = rv_pkg::alu_or;
                    3'b111: dec.alu_op = rv_pkg::alu_and;
                    default: legal = 1'b0;
                endcase
            end
            7'b0110011: begin
                dec.reg_write = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: dec.alu_op = rv_pkg::alu_add;
                    10'b0100000_000: dec.alu_op = rv_pkg::alu_sub;
                    10'b0000000_001: dec.alu_op = rv_pkg::alu_sll;
                    10'b0000000_010: dec.alu_op = rv_pkg::alu_slt;
                    10'b0000000_100: dec.alu_op = rv_pkg::alu_xor;
                    10'b0000000_101: dec.alu_op = rv_pkg::alu_srl;
                    10'b0100000_101: dec.alu_op = rv_pkg::alu_sra;
                    10'b0000000_110: dec.alu_op = rv_pkg::alu_or;
                    10'b0000000_111: dec.alu_op = rv_pkg::alu_and;
                    default: legal = 1'b0;
                endcase
            end
            7'b0011011: begin
                // addiw only
                dec.imm       = imm_i;
                dec.op_b_imm  = 1'b1;
                dec.is_word   = 1'b1;
                dec.wb_sel    = rv_pkg::wb_alu_w;
                dec.reg_write = 1'b1;
                legal         = (funct3 == 3'b000);
            end
            7'b0111011: begin
                dec.is_word   = 1'b1;
                dec.wb_sel    = rv_pkg::wb_alu_w;
                dec.reg_write = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: dec.alu_op = rv_pkg::alu_add;
                    10'b0000001_000: dec.alu_op = rv_pkg::alu_mulw;
                    10'b0000001_100: dec.alu_op = rv_pkg::alu_divw;
                    default: legal = 1'b0;
                endcase
            end
            7'b1101111: begin
                dec.imm       = imm_j;
                dec.jal       = 1'b1;
                dec.wb_sel    = rv_pkg::wb_pc4;
                dec.reg_write = 1'b1;
            end
            7'b1100111: begin
                dec.imm       = imm_i;
                dec.op_b_imm  = 1'b1;
                dec.jalr      = 1'b1;
                dec.wb_sel    = rv_pkg::wb_pc4;
                dec.reg_write = 1'b1;
                legal         = (funct3 == 3'b000);
            end
            7'b1100011: begin
                dec.imm = imm_b;
                case (funct3)
                    3'b000: dec.br_cond = rv_pkg::br_eq;
                    3'b001: dec.br_cond = rv_pkg::br_ne;
                    3'b100: dec.br_cond = rv_pkg::br_lt;
                    3'b101: dec.br_cond = rv_pkg::br_ge;
                    default: legal = 1'b0;
                endcase
            end
            7'b0000011: begin
                dec.imm       = imm_i;
                dec.op_b_imm  = 1'b1;
                dec.load      = 1'b1;
                dec.wb_sel    = rv_pkg::wb_load;
                dec.reg_write = 1'b1;
                case (funct3)
                    3'b000: dec.mem_size = rv_pkg::size_b;
                    3'b010: dec.mem_size = rv_pkg::size_w;
                    3'b011: dec.mem_size = rv_pkg::size_d;
                    3'b100: begin
                        dec.mem_size      = rv_pkg::size_b;
                        dec.load_unsigned = 1'b1;
                    end
                    default: legal = 1'b0;
                endcase
            end
            7'b0100011: begin
                dec.imm      = imm_s;
                dec.op_b_imm = 1'b1;
                dec.store    = 1'b1;
                case (funct3)
                    3'b000: dec.mem_size = rv_pkg::size_b;
                    3'b001: dec.mem_size = rv_pkg::size_h;
                    3'b010: dec.mem_size = rv_pkg::size_w;
                    3'b011: dec.mem_size = rv_pkg::size_d;
                    default: legal = 1'b0;
                endcase
            end
            7'b1110011: begin
                dec.ebreak = 1'b1;
                legal      = (instr == 32'h0010_0073);
            end
            default: legal = 1'b0;
        endcase

        // anything unrecognised becomes a nop
        if (!legal) begin
            dec = '0;
        end
    end

endmodule

/* source/rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [4:0]              rd,
    input  logic                    we,
    input  logic [rv_pkg::xlen-1:0] wdata,
    output logic [rv_pkg::xlen-1:0] src1,
    output logic [rv_pkg::xlen-1:0] src2,
    output logic [rv_pkg::xlen-1:0] a0
);

    logic [rv_pkg::xlen-1:0] regs [32];

    // x0 never gets written, so it reads back zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign src1 = regs[rs1];
    assign src2 = regs[rs2];
    assign a0   = regs[10];

endmodule

/* source/rv_execute.sv */
`timescale 1ns/100ps

module rv_execute (
    input  rv_pkg::dec_t            dec,
    input  logic [rv_pkg::xlen-1:0] pc,
    input  logic [rv_pkg::xlen-1:0] src1,
    input  logic [rv_pkg::xlen-1:0] src2,
    input  logic [rv_pkg::xlen-1:0] load_data,
    output logic [rv_pkg::xlen-1:0] alu_result,
    output logic [rv_pkg::xlen-1:0] next_pc,
    output logic [rv_pkg::xlen-1:0] rd_wdata
);

    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] op_b;
    logic [rv_pkg::xlen-1:0] pc_plus4;
    logic [5:0]              shamt;
    logic [31:0]             mul_lo;
    logic [31:0]             div_q;
    logic                    taken;

    assign op_a     = dec.op_a_pc ? pc : src1;
    assign op_b     = dec.op_b_imm ? dec.imm : src2;
    assign pc_plus4 = pc + 64'd4;
    assign shamt    = dec.is_word ? {1'b0, op_b[4:0]} : op_b[5:0];
    assign mul_lo   = op_a[31:0] * op_b[31:0];

    // divide by zero gives all ones, overflow returns the dividend
    always_comb begin
        if (op_b[31:0] == 32'd0) begin
            div_q = '1;
        end else if (op_a[31:0] == 32'h8000_0000 && op_b[31:0] == 32'hffff_ffff) begin
            div_q = 32'h8000_0000;
        end else begin
            div_q = $signed(op_a[31:0]) / $signed(op_b[31:0]);
        end
    end

    always_comb begin
        case (dec.alu_op)
            rv_pkg::alu_sub:  alu_result = op_a - op_b;
            rv_pkg::alu_and:  alu_result = op_a & op_b;
            rv_pkg::alu_or:   alu_result = op_a | op_b;
            rv_pkg::alu_xor:  alu_result = op_a ^ op_b;
            rv_pkg::alu_slt:  alu_result = {63'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::alu_sll:  alu_result = op_a << shamt;
            rv_pkg::alu_srl:  alu_result = op_a >> shamt;
            rv_pkg::alu_sra:  alu_result = $signed(op_a) >>> shamt;
            rv_pkg::alu_mulw: alu_result = {32'b0, mul_lo};
            rv_pkg::alu_divw: alu_result = {32'b0, div_q};
            default:          alu_result = op_a + op_b;
        endcase
    end

    always_comb begin
        case (dec.br_cond)
            rv_pkg::br_eq: taken = (src1 == src2);
            rv_pkg::br_ne: taken = (src1 != src2);
            rv_pkg::br_lt: taken = ($signed(src1) < $signed(src2));
            rv_pkg::br_ge: taken = ($signed(src1) >= $signed(src2));
            default:       taken = 1'b0;
        endcase
    end

    always_comb begin
        if (dec.jalr) begin
            next_pc = {alu_result[rv_pkg::xlen-1:1], 1'b0};
        end else if (dec.jal || taken) begin
            next_pc = pc + dec.imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_comb begin
        case (dec.wb_sel)
            rv_pkg::wb_alu_w: rd_wdata = {{32{alu_result[31]}}, alu_result[31:0]};
            rv_pkg::wb_upper: rd_wdata = dec.imm;
            rv_pkg::wb_pc4:   rd_wdata = pc_plus4;
            rv_pkg::wb_load:  rd_wdata = load_data;
            default:          rd_wdata = alu_result;
        endcase
    end

endmodule

/* source/rv_lsu.sv */
`timescale 1ns/100ps

module rv_lsu (
    input  rv_pkg::dec_t            dec,
    input  logic [rv_pkg::xlen-1:0] addr,
    input  logic [rv_pkg::xlen-1:0] src2,
    input  logic                    halt,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata,
    output rv_pkg::mem_req_t        dmem_req,
    output logic [rv_pkg::xlen-1:0] load_data
);

    logic [2:0]              lane;
    logic [7:0]              size_mask;
    logic [rv_pkg::xlen-1:0] rd_shifted;
    logic                    do_store;
    logic                    do_load;

    assign lane     = addr[2:0];
    assign do_store = dec.store && !halt;
    assign do_load  = dec.load && !halt;

    always_comb begin
        case (dec.mem_size)
            rv_pkg::size_b: size_mask = 8'h01;
            rv_pkg::size_h: size_mask = 8'h03;
            rv_pkg::size_w: size_mask = 8'h0f;
            default:        size_mask = 8'hff;
        endcase
    end

    // store data and mask moved up to the addressed byte lane
    always_comb begin
        dmem_req.addr  = addr;
        dmem_req.wdata = src2 << {lane, 3'b000};
        dmem_req.wmask = do_store ? (size_mask << lane) : 8'h00;
        dmem_req.we    = do_store;
        dmem_req.re    = do_load;
    end

    assign rd_shifted = dmem_rdata >> {lane, 3'b000};

    always_comb begin
        case (dec.mem_size)
            rv_pkg::size_b: begin
                if (dec.load_unsigned) load_data = {56'b0, rd_shifted[7:0]};
                else load_data = {{56{rd_shifted[7]}}, rd_shifted[7:0]};
            end
            rv_pkg::size_w: load_data = {{32{rd_shifted[31]}}, rd_shifted[31:0]};
            default: load_data = rd_shifted;
        endcase
    end

endmodule

/* source/rv_core.sv */
`timescale 1ns/100ps

module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = 64'h8000_0000
) (
    input  logic                    clk,
    input  logic                    arst_n,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    input  logic [31:0]             imem_data,
    output rv_pkg::mem_req_t        dmem_req,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata,
    output logic                    halt,
    output logic [rv_pkg::xlen-1:0] exit_code
);

    rv_pkg::dec_t            dec;
    logic [rv_pkg::xlen-1:0] pc;
    logic [rv_pkg::xlen-1:0] next_pc;
    logic [rv_pkg::xlen-1:0] src1;
    logic [rv_pkg::xlen-1:0] src2;
    logic [rv_pkg::xlen-1:0] a0;
    logic [rv_pkg::xlen-1:0] alu_result;
    logic [rv_pkg::xlen-1:0] rd_wdata;
    logic [rv_pkg::xlen-1:0] load_data;

    assign imem_addr = pc;

    rv_fetch #(
        .reset_pc(reset_pc)
    ) u_fetch (
        .clk      (clk),
        .arst_n   (arst_n),
        .next_pc  (next_pc),
        .halt_req (dec.ebreak),
        .a0_value (a0),
        .pc       (pc),
        .halt     (halt),
        .exit_code(exit_code)
    );

    rv_decode u_decode (
        .instr(imem_data),
        .dec  (dec)
    );

    rv_regfile u_regfile (
        .clk   (clk),
        .arst_n(arst_n),
        .rs1   (dec.rs1),
        .rs2   (dec.rs2),
        .rd    (dec.rd),
        .we    (dec.reg_write),
        .wdata (rd_wdata),
        .src1  (src1),
        .src2  (src2),
        .a0    (a0)
    );

    rv_execute u_execute (
        .dec       (dec),
        .pc        (pc),
        .src1      (src1),
        .src2      (src2),
        .load_data (load_data),
        .alu_result(alu_result),
        .next_pc   (next_pc),
        .rd_wdata  (rd_wdata)
    );

    rv_lsu u_lsu (
        .dec       (dec),
        .addr      (alu_result),
        .src2      (src2),
        .halt      (halt),
        .dmem_rdata(dmem_rdata),
        .dmem_req  (dmem_req),
        .load_data (load_data)
    );

endmodule

/* tests/rv_core_programs.svh */
`ifndef RV_CORE_PROGRAMS_SVH
`define RV_CORE_PROGRAMS_SVH

function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    r_type = {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd, logic [6:0] op);
    i_type = {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    s_type = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    b_type = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
    j_type = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

task automatic emit(logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
endtask

// expected request for a store of size bytes at a full address
task automatic expect_store(string name, logic [63:0] addr, int size, logic [63:0] value);
    logic [7:0]  mask;
    logic [63:0] data;
    mask = 8'h00;
    for (int k = 0; k < size; k++) begin
        mask[k] = 1'b1;
    end
    mask = mask << addr[2:0];
    data = (value << (8 * addr[2:0])) & expand_mask(mask);
    exp_name.push_back(name);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_mask.push_back(mask);
endtask

// sd of a result register into the next result slot
task automatic store_result(string name, logic [4:0] rs, logic [63:0] value);
    emit(s_type(slot, rs, 5'd2, 3'b011));
    expect_store(name, data_base + {52'b0, slot}, 8, value);
    slot = slot + 12'd8;
endtask

// lui + addiw gives the 32-bit value sign extended
task automatic load_const(logic [4:0] rd, logic [31:0] v, output logic [63:0] value);
    logic [31:0] hi;
    hi = v + 32'h800;
    emit({hi[31:12], rd, 7'b0110111});
    emit(i_type(v[11:0], rd, 3'b000, rd, 7'b0011011));
    value = sext32(v);
endtask

task automatic rop(string name, logic [6:0] f7, logic [2:0] f3, logic [63:0] value);
    emit(r_type(f7, 5'd6, 5'd5, f3, 5'd7, 7'b0110011));
    store_result(name, 5'd7, value);
endtask

task automatic iop(string name, logic [11:0] imm, logic [2:0] f3, logic [63:0] value);
    emit(i_type(imm, 5'd5, f3, 5'd7, 7'b0010011));
    store_result(name, 5'd7, value);
endtask

task automatic wop(string name, logic [6:0] f7, logic [2:0] f3, logic [4:0] rs2,
                   logic [63:0] value);
    emit(r_type(f7, rs2, 5'd5, f3, 5'd7, 7'b0111011));
    store_result(name, 5'd7, value);
endtask

`endif

/* tests/rv_core_tb.sv */
`timescale 1ns/100ps

module rv_core_tb;

    localparam logic [63:0] reset_pc  = 64'h8000_0000;
    localparam logic [63:0] data_base = 64'h1000;

    logic                clk;
    logic                arst_n;
    logic [63:0]         imem_addr;
    logic [31:0]         imem_data;
    rv_pkg::mem_req_t    dreq;
    logic [63:0]         dmem_rdata;
    logic                halt;
    logic [63:0]         exit_code;

    logic [31:0]         imem [256];
    logic [63:0]         dmem [256];
    int                  prog_len;
    logic [11:0]         slot;
    int                  seed;
    int                  errors;
    int                  checks;
    logic                built;
    logic [63:0]         exit_exp;
    logic [63:0]         imem_idx;

    string               exp_name [$];
    logic [63:0]         exp_addr [$];
    logic [63:0]         exp_data [$];
    logic [7:0]          exp_mask [$];
    string               exp_load_name [$];
    logic [63:0]         exp_load [$];

    function automatic logic [63:0] sext32(logic [31:0] v);
        sext32 = {{32{v[31]}}, v};
    endfunction

    function automatic logic [63:0] sext8(logic [7:0] v);
        sext8 = {{56{v[7]}}, v};
    endfunction

    function automatic logic [63:0] fill_word(int idx);
        fill_word = {8{idx[7:0]}} ^ 64'h0123_4567_89ab_cdef;
    endfunction

    function automatic logic [63:0] expand_mask(logic [7:0] m);
        for (int k = 0; k < 8; k++) begin
            expand_mask[8*k +: 8] = {8{m[k]}};
        end
    endfunction

    `include "rv_core_programs.svh"

    task automatic build_program();
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        logic [63:0] shadow;
        logic [63:0] p;
        logic [63:0] q;
        logic [11:0] imm;
        logic [5:0]  sh;
        int          n;
        prog_len = 0;
        slot     = 12'd0;
        emit({20'h00001, 5'd2, 7'b0110111});
        load_const(5'd5, $random(seed), a);
        load_const(5'd6, $random(seed), b);
        imm = 12'($random(seed));
        sh  = 6'($random(seed));

        rop("add", 7'h00, 3'd0, a + b);
        rop("sub", 7'h20, 3'd0, a - b);
        rop("and", 7'h00, 3'd7, a & b);
        rop("or", 7'h00, 3'd6, a | b);
        rop("xor", 7'h00, 3'd4, a ^ b);
        rop("slt", 7'h00, 3'd2, {63'b0, $signed(a) < $signed(b)});
        rop("sll", 7'h00, 3'd1, a << b[5:0]);
        rop("srl", 7'h00, 3'd5, a >> b[5:0]);
        rop("sra", 7'h20, 3'd5, $signed(a) >>> b[5:0]);
        c = {{52{imm[11]}}, imm};
        iop("addi", imm, 3'd0, a + c);
        iop("andi", imm, 3'd7, a & c);
        iop("ori", imm, 3'd6, a | c);
        iop("xori", imm, 3'd4, a ^ c);
        iop("slti", imm, 3'd2, {63'b0, $signed(a) < $signed(c)});
        iop("slli", {6'h00, sh}, 3'd1, a << sh);
        iop("srli", {6'h00, sh}, 3'd5, a >> sh);
        iop("srai", {6'h10, sh}, 3'd5, $signed(a) >>> sh);

        wop("addw", 7'h00, 3'd0, 5'd6, sext32(a[31:0] + b[31:0]));
        emit(i_type(imm, 5'd5, 3'd0, 5'd7, 7'b0011011));
        store_result("addiw", 5'd7, sext32(a[31:0] + c[31:0]));
        p = {32'b0, a[31:0]} * {32'b0, b[31:0]};
        wop("mulw", 7'h01, 3'd0, 5'd6, sext32(p[31:0]));
        if (b[31:0] == 32'd0) begin
            q = 64'hffff_ffff;
        end else begin
            q = $signed(sext32(a[31:0])) / $signed(sext32(b[31:0]));
        end
        wop("divw", 7'h01, 3'd4, 5'd6, sext32(q[31:0]));
        wop("divw_zero", 7'h01, 3'd4, 5'd0, 64'hffff_ffff_ffff_ffff);

        // lane region at base + 0x400, sign bits forced on
        load_const(5'd12, a[31:0] | 32'h8000_8080, c);
        shadow = fill_word(int'((data_base + 64'h400) >> 3) & 255);
        for (int off = 0; off < 8; off++) begin
            emit(s_type(12'h400 + 12'(off), 5'd12, 5'd2, 3'd0));
            expect_store("sb", data_base + 64'h400 + 64'(off), 1, c);
            shadow[8*off +: 8] = c[7:0];
        end
        for (int off = 0; off < 8; off += 2) begin
            emit(s_type(12'h400 + 12'(off), 5'd12, 5'd2, 3'd1));
            expect_store("sh", data_base + 64'h400 + 64'(off), 2, c);
            shadow[8*off +: 16] = c[15:0];
        end
        for (int off = 0; off < 8; off += 4) begin
            emit(s_type(12'h400 + 12'(off), 5'd12, 5'd2, 3'd2));
            expect_store("sw", data_base + 64'h400 + 64'(off), 4, c);
            shadow[8*off +: 32] = c[31:0];
        end
        emit(i_type(12'h403, 5'd2, 3'd0, 5'd7, 7'b0000011));
        exp_load_name.push_back("lb");
        exp_load.push_back(data_base + 64'h403);
        store_result("lb", 5'd7, sext8(shadow[31:24]));
        emit(i_type(12'h405, 5'd2, 3'd4, 5'd7, 7'b0000011));
        exp_load_name.push_back("lbu");
        exp_load.push_back(data_base + 64'h405);
        store_result("lbu", 5'd7, {56'b0, shadow[47:40]});
        emit(i_type(12'h404, 5'd2, 3'd2, 5'd7, 7'b0000011));
        exp_load_name.push_back("lw");
        exp_load.push_back(data_base + 64'h404);
        store_result("lw", 5'd7, sext32(shadow[63:32]));
        emit(i_type(12'h400, 5'd2, 3'd3, 5'd7, 7'b0000011));
        exp_load_name.push_back("ld");
        exp_load.push_back(data_base + 64'h400);
        store_result("ld", 5'd7, shadow);

        n = 3 + ($random(seed) & 7);
        emit(i_type(12'd0, 5'd0, 3'd0, 5'd8, 7'b0010011));
        emit(i_type(12'(n), 5'd0, 3'd0, 5'd9, 7'b0010011));
        emit(i_type(12'd1, 5'd8, 3'd0, 5'd8, 7'b0010011));
        emit(b_type(-13'sd4, 5'd9, 5'd8, 3'd1));
        store_result("bne_loop", 5'd8, 64'(n));
        emit(i_type(12'd0, 5'd0, 3'd0, 5'd11, 7'b0010011));
        emit(i_type(12'd2, 5'd11, 3'd0, 5'd11, 7'b0010011));
        emit(b_type(-13'sd4, 5'd9, 5'd11, 3'd4));
        store_result("blt_loop", 5'd11, 64'(((n + 1) / 2) * 2));

        // call a two-instruction routine and come back
        emit(i_type(12'd0, 5'd0, 3'd0, 5'd13, 7'b0010011));
        p = reset_pc + 64'(4 * prog_len);
        emit(j_type(21'd12, 5'd1));
        store_result("jal_link", 5'd1, p + 64'd4);
        emit(j_type(21'd12, 5'd0));
        emit(i_type(12'd7, 5'd13, 3'd0, 5'd13, 7'b0010011));
        emit(i_type(12'd0, 5'd1, 3'd0, 5'd0, 7'b1100111));
        store_result("call_body", 5'd13, 64'd7);
        emit(i_type(12'd5, 5'd0, 3'd0, 5'd0, 7'b0010011));
        store_result("x0_write", 5'd0, 64'd0);

        load_const(5'd10, $random(seed), exit_exp);
        emit(32'h0010_0073);
        // must never execute
        emit(s_type(slot, 5'd10, 5'd2, 3'b011));
    endtask

    rv_core #(
        .reset_pc(reset_pc)
    ) UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .dmem_req  (dreq),
        .dmem_rdata(dmem_rdata),
        .halt      (halt),
        .exit_code (exit_code)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    assign imem_idx   = (imem_addr - reset_pc) >> 2;
    assign imem_data  = (imem_idx < 64'd256) ? imem[imem_idx[7:0]] : 32'h0000_0013;
    assign dmem_rdata = dmem[dreq.addr[10:3]];

    always @(posedge clk) begin
        if (dreq.we) begin
            for (int k = 0; k < 8; k++) begin
                if (dreq.wmask[k]) begin
                    dmem[dreq.addr[10:3]][8*k +: 8] <= dreq.wdata[8*k +: 8];
                end
            end
        end
    end

    // every store and load is matched against the head of its expected queue
    always @(posedge clk) begin
        string       name;
        logic [63:0] e_addr;
        logic [63:0] e_data;
        logic [7:0]  e_mask;
        if (arst_n && dreq.we) begin
            checks++;
            if (exp_name.size() == 0) begin
                $display("unexpected store to address %h after the last expected one",
                         dreq.addr);
                errors++;
            end else begin
                name   = exp_name.pop_front();
                e_addr = exp_addr.pop_front();
                e_data = exp_data.pop_front();
                e_mask = exp_mask.pop_front();
                assert (dreq.addr == e_addr) else begin
                    $display("** Error %s addr: expected %h, actual %h", name, e_addr, dreq.addr);
                    errors++;
                end
                assert (dreq.wmask == e_mask) else begin
                    $display("** Error %s mask: expected %h, actual %h", name, e_mask, dreq.wmask);
                    errors++;
                end
                assert ((dreq.wdata & expand_mask(e_mask)) == e_data) else begin
                    $display("** Error %s data: expected %h, actual %h", name, e_data,
                             dreq.wdata & expand_mask(e_mask));
                    errors++;
                end
            end
        end
        if (arst_n && dreq.re) begin
            checks++;
            if (exp_load.size() == 0) begin
                $display("unexpected load from address %h", dreq.addr);
                errors++;
            end else begin
                name   = exp_load_name.pop_front();
                e_addr = exp_load.pop_front();
                assert (dreq.addr == e_addr) else begin
                    $display("** Error %s load addr: expected %h, actual %h", name, e_addr,
                             dreq.addr);
                    errors++;
                end
            end
        end
    end

    initial begin
        wait (built === 1'b1);
        #((prog_len * 20 + 100) * 10);
        $display("timeout: the core never halted");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        built  = 1'b0;
        arst_n = 1'b0;
        errors = 0;
        checks = 0;
        seed   = 32'ha79f;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0000_0013;
            dmem[i] = fill_word(i);
        end
        build_program();
        built = 1'b1;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        wait (halt === 1'b1);
        repeat (10) begin
            @(posedge clk);
            checks++;
            assert (halt === 1'b1) else begin
                $display("halt dropped after the core had halted");
                errors++;
            end
        end
        checks++;
        assert (exit_code == exit_exp) else begin
            $display("** Error exit_code: expected %h, actual %h", exit_exp, exit_code);
            errors++;
        end
        if (exp_name.size() != 0) begin
            $display("%0d expected stores never appeared, first is %s",
                     exp_name.size(), exp_name[0]);
            errors++;
        end
        if (exp_load.size() != 0) begin
            $display("%0d expected loads never appeared, first is %s",
                     exp_load.size(), exp_load_name[0]);
            errors++;
        end
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* rv_core.f */
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_lsu.sv
source/rv_core.sv
+incdir+tests
tests/rv_core_tb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module rv_core_tb -f rv_core.f -o rv_core_sim
./obj_dir/rv_core_sim | tee sim.log

grep -q "Result: PASSED" sim.log
